//--- common/rv_isa_pkg.sv
package rv_isa_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Word and field widths
    localparam int XLEN           = 32;
    localparam int REG_ADDR_W     = 5;
    localparam int FN3_W          = 3;
    localparam int OPCODE_GROUP_W = 5;  // Opcode without the two low bits

    // Field positions inside the instruction word
    localparam int OPCODE_GROUP_LSB = 2;  // Bits 1:0 are always 11 for 32-bit ops
    localparam int RD_LSB           = 7;
    localparam int FN3_LSB          = 12;
    localparam int RS1_LSB          = 15;
    localparam int FN7_MUL_BIT      = 25; // M extension marker in ARITH ops
    localparam int FN7_SUB_BIT      = 30; // SUB and SRA marker

    ////////////////////////////////////////////////////////////////////////////
    // Plain vector types
    typedef logic [XLEN-1:0]       instruction_t;
    typedef logic [XLEN-1:0]       addr_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [FN3_W-1:0]      fn3_t;

    // Trimmed opcodes, instruction bits 6:2
    typedef enum logic [OPCODE_GROUP_W-1:0] {
        LOAD_T      = 5'b00000,
        FENCE_T     = 5'b00011,
        ARITH_IMM_T = 5'b00100,
        AUIPC_T     = 5'b00101,
        STORE_T     = 5'b01000,
        AMO_T       = 5'b01011,
        ARITH_T     = 5'b01100,
        LUI_T       = 5'b01101,
        BRANCH_T    = 5'b11000,
        JALR_T      = 5'b11001,
        JAL_T       = 5'b11011,
        SYSTEM_T    = 5'b11100  // CSR ops, ECALL, EBREAK, xRET
    } opcode_group_t;

    ////////////////////////////////////////////////////////////////////////////
    // fn3 codes of the integer ops
    localparam fn3_t ADD_SUB_FN3 = 3'b000;
    localparam fn3_t SLL_FN3     = 3'b001;
    localparam fn3_t SLT_FN3     = 3'b010;
    localparam fn3_t SLTU_FN3    = 3'b011;
    localparam fn3_t XOR_FN3     = 3'b100;
    localparam fn3_t SRA_FN3     = 3'b101;  // SRL shares this code
    localparam fn3_t OR_FN3      = 3'b110;
    localparam fn3_t AND_FN3     = 3'b111;

    // Link registers seen by the return-address stack
    localparam reg_addr_t LINK_REG_A = 5'd1;  // ra
    localparam reg_addr_t LINK_REG_B = 5'd5;  // t0, alternate link

endpackage

//--- common/fetch_buffer_pkg.sv
package fetch_buffer_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Branch predictor side
    localparam int BP_WAYS           = 2;
    localparam int BRANCH_METADATA_W = 32;

    typedef logic [BP_WAYS-1:0]           bp_way_t;           // One-hot
    typedef logic [BRANCH_METADATA_W-1:0] branch_metadata_t;  // Opaque here

    ////////////////////////////////////////////////////////////////////////////
    // ALU control encodings
    typedef enum logic [1:0] {
        ALU_LOGIC_ADD = 2'd0,  // Adder path, also SLT[U] and shifts
        ALU_LOGIC_XOR = 2'd1,
        ALU_LOGIC_OR  = 2'd2,
        ALU_LOGIC_AND = 2'd3
    } alu_logic_op_t;

    typedef enum logic [1:0] {
        ALU_RS1_RF   = 2'd0,
        ALU_RS1_PC   = 2'd1,  // AUIPC, JAL, JALR
        ALU_RS1_ZERO = 2'd2   // LUI
    } alu_rs1_sel_t;

    typedef enum logic [1:0] {
        ALU_RS2_RF        = 2'd0,
        ALU_RS2_ARITH_IMM = 2'd1,
        ALU_RS2_JAL_JALR  = 2'd2,  // Link value offset
        ALU_RS2_LUI_AUIPC = 2'd3   // Upper immediate
    } alu_rs2_sel_t;

    ////////////////////////////////////////////////////////////////////////////
    // What fetch hands over each push
    typedef struct packed {
        rv_isa_pkg::instruction_t instruction;
        rv_isa_pkg::addr_t        pc;
        branch_metadata_t         branch_metadata;
        logic                     prediction_used;
        bp_way_t                  update_way;
    } fetch_packet_t;

    // Fetch packet plus pre-decoded control
    typedef struct packed {
        fetch_packet_t fetch;
        logic          is_call;    // Push onto RAS
        logic          is_return;  // Pop from RAS
        logic          uses_rs1;
        logic          uses_rs2;
        logic          uses_rd;
        logic          alu_request;
        logic          alu_sub;
        alu_logic_op_t alu_logic_op;
        alu_rs1_sel_t  alu_rs1_sel;
        alu_rs2_sel_t  alu_rs2_sel;
    } fetch_buffer_packet_t;

endpackage

//--- pre_decode/fetch_fifo.sv
module fetch_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                                   clk,
    input  logic                                   clear,
    input  logic                                   push,
    input  logic                                   pop,
    input  fetch_buffer_pkg::fetch_buffer_packet_t data_in,
    output fetch_buffer_pkg::fetch_buffer_packet_t data_out,
    output logic                                   valid,
    output logic                                   full
);

    localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_W = $clog2(DEPTH + 1);

    typedef logic [PTR_W-1:0]   ptr_t;
    typedef logic [COUNT_W-1:0] count_t;

    fetch_buffer_pkg::fetch_buffer_packet_t mem [DEPTH];  // Payload only

    ptr_t   rd_ptr;
    ptr_t   wr_ptr;
    count_t count;

    // Wrap at DEPTH, not at a power of two
    function automatic ptr_t next_ptr(input ptr_t ptr);
        next_ptr = (ptr == ptr_t'(DEPTH - 1)) ? '0 : ptr_t'(ptr + 1'b1);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= data_in;  // Full with pop overwrites the head being read
    end

    assign data_out = mem[rd_ptr];  // Head shown combinationally

    ////////////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (clear) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle or push with pop
            endcase
        end
    end

    assign valid = (count != '0);
    assign full  = (count == count_t'(DEPTH));

    ////////////////////////////////////////////////////////////////////////////
    // Guards
    // Fetch overran its DEPTH+1 outstanding limit
    overflow_chk: assert property (@(posedge clk) disable iff (clear)
        !(push && full && !pop))
        else $error("fetch_fifo: push while full");

    underflow_chk: assert property (@(posedge clk) disable iff (clear)
        !(pop && !valid))
        else $error("fetch_fifo: pop while empty");

endmodule

//--- pre_decode/pre_decode.sv
module pre_decode #(
    parameter int FETCH_BUFFER_DEPTH = 4
) (
    input  logic                                   clk,
    input  logic                                   buffer_reset,
    input  logic                                   flush,
    input  logic                                   push,
    input  fetch_buffer_pkg::fetch_packet_t        fetch_in,
    input  logic                                   pop,
    output logic                                   fb_valid,
    output fetch_buffer_pkg::fetch_buffer_packet_t fb
);

    logic queue_clear;

    // Instruction fields
    rv_isa_pkg::instruction_t  instr;
    rv_isa_pkg::opcode_group_t opcode_group;
    rv_isa_pkg::fn3_t          fn3;
    rv_isa_pkg::reg_addr_t     rs1_addr;
    rv_isa_pkg::reg_addr_t     rd_addr;

    logic csr_imm_op;
    logic sys_op;
    logic upper_or_jump;
    logic rs1_link;
    logic rd_link;
    logic is_call;
    logic is_return;
    logic uses_rs1;
    logic uses_rs2;
    logic uses_rd;
    logic sub_op;
    logic plain_arith_op;
    logic alu_request;
    logic alu_sub;

    fetch_buffer_pkg::alu_logic_op_t alu_logic_op;
    fetch_buffer_pkg::alu_rs1_sel_t  alu_rs1_sel;
    fetch_buffer_pkg::alu_rs2_sel_t  alu_rs2_sel;

    fetch_buffer_pkg::fetch_buffer_packet_t decoded;    // This cycle's push
    fetch_buffer_pkg::fetch_buffer_packet_t fifo_head;
    fetch_buffer_pkg::fetch_buffer_packet_t next_fb;

    logic fifo_push;
    logic fifo_pop;
    logic fifo_valid;
    logic fifo_full;

    ////////////////////////////////////////////////////////////////////////////
    // Queue control and bypass
    assign queue_clear = buffer_reset | flush;

    // FIFO only when output register stays occupied or older packets wait
    assign fifo_push = push & ((fb_valid & ~pop) | fifo_valid);
    assign fifo_pop  = pop & fifo_valid;

    assign next_fb = fifo_valid ? fifo_head : decoded;  // Bypass when FIFO empty

    always_ff @(posedge clk) begin
        if (!fb_valid || pop)
            fb <= next_fb;
    end

    always_ff @(posedge clk) begin
        if (queue_clear)
            fb_valid <= 1'b0;
        else
            fb_valid <= push | (fb_valid & ~(pop & ~fifo_valid));
    end

    fetch_fifo #(
        .DEPTH(FETCH_BUFFER_DEPTH)
    ) fifo0 (
        .clk     (clk),
        .clear   (queue_clear),
        .push    (fifo_push),
        .pop     (fifo_pop),
        .data_in (decoded),
        .data_out(fifo_head),
        .valid   (fifo_valid),
        .full    (fifo_full)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Field extraction
    assign instr        = fetch_in.instruction;
    assign opcode_group = rv_isa_pkg::opcode_group_t'(
        instr[rv_isa_pkg::OPCODE_GROUP_LSB +: rv_isa_pkg::OPCODE_GROUP_W]);
    assign fn3          = instr[rv_isa_pkg::FN3_LSB +: rv_isa_pkg::FN3_W];
    assign rs1_addr     = instr[rv_isa_pkg::RS1_LSB +: rv_isa_pkg::REG_ADDR_W];
    assign rd_addr      = instr[rv_isa_pkg::RD_LSB +: rv_isa_pkg::REG_ADDR_W];

    assign csr_imm_op    = (opcode_group == rv_isa_pkg::SYSTEM_T) && fn3[2];
    assign sys_op        = (opcode_group == rv_isa_pkg::SYSTEM_T) && (fn3 == 3'b000);
    assign upper_or_jump = opcode_group[0];  // Opcode bit 2, LUI AUIPC JAL JALR

    ////////////////////////////////////////////////////////////////////////////
    // RAS hints
    assign rs1_link = rs1_addr inside {rv_isa_pkg::LINK_REG_A, rv_isa_pkg::LINK_REG_B};
    assign rd_link  = rd_addr inside {rv_isa_pkg::LINK_REG_A, rv_isa_pkg::LINK_REG_B};

    assign is_call   = (opcode_group inside {rv_isa_pkg::JAL_T, rv_isa_pkg::JALR_T}) && rd_link;
    // Link to same link register is a call only, never a return
    assign is_return = (opcode_group == rv_isa_pkg::JALR_T) && rs1_link
                       && (!rd_link || (rs1_addr != rd_addr));

    // Register file usage
    assign uses_rs1 = !((opcode_group inside {rv_isa_pkg::LUI_T, rv_isa_pkg::AUIPC_T,
                                              rv_isa_pkg::JAL_T, rv_isa_pkg::FENCE_T})
                        || csr_imm_op || sys_op);
    assign uses_rs2 = opcode_group inside {rv_isa_pkg::BRANCH_T, rv_isa_pkg::STORE_T,
                                           rv_isa_pkg::ARITH_T, rv_isa_pkg::AMO_T};
    assign uses_rd  = !((opcode_group inside {rv_isa_pkg::BRANCH_T, rv_isa_pkg::STORE_T,
                                              rv_isa_pkg::FENCE_T}) || sys_op);

    ////////////////////////////////////////////////////////////////////////////
    // ALU control
    // SUB only from register form, ADDI has no fn7
    assign sub_op  = (fn3 == rv_isa_pkg::ADD_SUB_FN3)
                     && instr[rv_isa_pkg::FN7_SUB_BIT] && (opcode_group == rv_isa_pkg::ARITH_T);
    assign alu_sub = ~upper_or_jump
                     & ((fn3 inside {rv_isa_pkg::SLT_FN3, rv_isa_pkg::SLTU_FN3}) || sub_op);

    assign plain_arith_op = (opcode_group == rv_isa_pkg::ARITH_T)
                            && !instr[rv_isa_pkg::FN7_MUL_BIT];  // MUL/DIV go elsewhere
    assign alu_request    = plain_arith_op
                            || (opcode_group inside {rv_isa_pkg::ARITH_IMM_T, rv_isa_pkg::AUIPC_T,
                                                     rv_isa_pkg::LUI_T, rv_isa_pkg::JAL_T,
                                                     rv_isa_pkg::JALR_T});

    always_comb begin
        case (fn3)
            rv_isa_pkg::XOR_FN3: alu_logic_op = fetch_buffer_pkg::ALU_LOGIC_XOR;
            rv_isa_pkg::OR_FN3:  alu_logic_op = fetch_buffer_pkg::ALU_LOGIC_OR;
            rv_isa_pkg::AND_FN3: alu_logic_op = fetch_buffer_pkg::ALU_LOGIC_AND;
            default:             alu_logic_op = fetch_buffer_pkg::ALU_LOGIC_ADD;
        endcase
        if (upper_or_jump)
            alu_logic_op = fetch_buffer_pkg::ALU_LOGIC_ADD;  // fn3 bits are immediate here
    end

    always_comb begin
        if (opcode_group inside {rv_isa_pkg::ARITH_T, rv_isa_pkg::ARITH_IMM_T})
            alu_rs1_sel = fetch_buffer_pkg::ALU_RS1_RF;
        else if (opcode_group inside {rv_isa_pkg::JAL_T, rv_isa_pkg::JALR_T, rv_isa_pkg::AUIPC_T})
            alu_rs1_sel = fetch_buffer_pkg::ALU_RS1_PC;
        else
            alu_rs1_sel = fetch_buffer_pkg::ALU_RS1_ZERO;  // LUI
    end

    always_comb begin
        if (opcode_group inside {rv_isa_pkg::LUI_T, rv_isa_pkg::AUIPC_T})
            alu_rs2_sel = fetch_buffer_pkg::ALU_RS2_LUI_AUIPC;
        else if (opcode_group == rv_isa_pkg::ARITH_IMM_T)
            alu_rs2_sel = fetch_buffer_pkg::ALU_RS2_ARITH_IMM;
        else if (opcode_group inside {rv_isa_pkg::JAL_T, rv_isa_pkg::JALR_T})
            alu_rs2_sel = fetch_buffer_pkg::ALU_RS2_JAL_JALR;
        else
            alu_rs2_sel = fetch_buffer_pkg::ALU_RS2_RF;
    end

    assign decoded = '{fetch: fetch_in, is_call: is_call, is_return: is_return,
                       uses_rs1: uses_rs1, uses_rs2: uses_rs2, uses_rd: uses_rd,
                       alu_request: alu_request, alu_sub: alu_sub,
                       alu_logic_op: alu_logic_op, alu_rs1_sel: alu_rs1_sel,
                       alu_rs2_sel: alu_rs2_sel};

    ////////////////////////////////////////////////////////////////////////////
    // Decode side protocol
    pop_valid_chk: assert property (@(posedge clk) disable iff (buffer_reset)
        pop |-> fb_valid)
        else $error("pre_decode: pop without fb_valid");

    // No free slot left behind the output register
    capacity_chk: assert property (@(posedge clk) disable iff (queue_clear)
        !(fifo_push && fifo_full && !fifo_pop))
        else $error("pre_decode: push beyond buffer capacity");

endmodule

//--- source/fetch_decode_top.sv
module fetch_decode_top #(
    parameter int FETCH_BUFFER_DEPTH = 4  // FIFO entries behind the output register
) (
    input  logic                                   clk,
    input  logic                                   buffer_reset,
    input  logic                                   flush,

    // Fetch side
    input  logic                                   push,
    input  fetch_buffer_pkg::fetch_packet_t        fetch_in,

    // Decode side
    input  logic                                   pop,
    output logic                                   fb_valid,
    output fetch_buffer_pkg::fetch_buffer_packet_t fb
);

    ////////////////////////////////////////////////////////////////////////////
    // Fetch buffer with pre-decode
    pre_decode #(
        .FETCH_BUFFER_DEPTH(FETCH_BUFFER_DEPTH)
    ) pre_decode0 (
        .clk         (clk),
        .buffer_reset(buffer_reset),
        .flush       (flush),     // Level, empties the buffer
        .push        (push),
        .fetch_in    (fetch_in),
        .pop         (pop),
        .fb_valid    (fb_valid),
        .fb          (fb)
    );

endmodule

//--- dv/tb_fetch_decode.sv
module tb_fetch_decode;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int FETCH_BUFFER_DEPTH = 4;
    localparam int OUTSTANDING_MAX    = FETCH_BUFFER_DEPTH + 1;  // FIFO plus output register
    localparam int WAIT_LIMIT         = 50;
    localparam int RESET_CYCLES       = 16;

    logic clk;
    logic buffer_reset;
    logic flush;
    logic push;
    logic pop;
    logic fb_valid;

    fetch_buffer_pkg::fetch_packet_t        fetch_in;
    fetch_buffer_pkg::fetch_buffer_packet_t fb;

    fetch_buffer_pkg::fetch_buffer_packet_t expected_q [$];  // Scoreboard, push order
    fetch_buffer_pkg::fetch_buffer_packet_t pending_q  [$];  // Burst extras, pushed with pops

    int   errors;
    int   checks;
    logic aborted;  // Set on a timeout or a bad file

    fetch_decode_top #(
        .FETCH_BUFFER_DEPTH(FETCH_BUFFER_DEPTH)
    ) dut0 (
        .clk         (clk),
        .buffer_reset(buffer_reset),
        .flush       (flush),
        .push        (push),
        .fetch_in    (fetch_in),
        .pop         (pop),
        .fb_valid    (fb_valid),
        .fb          (fb)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    // Edge plus 1 ns, where inputs change and outputs are settled
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_packet(input fetch_buffer_pkg::fetch_buffer_packet_t exp);
        check_value("fb.instruction", fb.fetch.instruction, exp.fetch.instruction);
        check_value("fb.pc", fb.fetch.pc, exp.fetch.pc);
        check_value("fb.branch_metadata", fb.fetch.branch_metadata, exp.fetch.branch_metadata);
        check_value("fb.prediction_used", 32'(fb.fetch.prediction_used),
                    32'(exp.fetch.prediction_used));
        check_value("fb.update_way", 32'(fb.fetch.update_way), 32'(exp.fetch.update_way));
        check_value("fb.is_call", 32'(fb.is_call), 32'(exp.is_call));
        check_value("fb.is_return", 32'(fb.is_return), 32'(exp.is_return));
        check_value("fb.uses_rs1", 32'(fb.uses_rs1), 32'(exp.uses_rs1));
        check_value("fb.uses_rs2", 32'(fb.uses_rs2), 32'(exp.uses_rs2));
        check_value("fb.uses_rd", 32'(fb.uses_rd), 32'(exp.uses_rd));
        check_value("fb.alu_request", 32'(fb.alu_request), 32'(exp.alu_request));
        check_value("fb.alu_sub", 32'(fb.alu_sub), 32'(exp.alu_sub));
        check_value("fb.alu_logic_op", 32'(fb.alu_logic_op), 32'(exp.alu_logic_op));
        check_value("fb.alu_rs1_sel", 32'(fb.alu_rs1_sel), 32'(exp.alu_rs1_sel));
        check_value("fb.alu_rs2_sel", 32'(fb.alu_rs2_sel), 32'(exp.alu_rs2_sel));
    endtask

    // Poll fb_valid once per edge, give up after WAIT_LIMIT cycles
    task automatic wait_valid();
        int cycles;
        cycles = 0;
        while (!fb_valid && cycles < WAIT_LIMIT) begin
            tick();
            cycles++;
        end
        assert (fb_valid === 1'b1)
        else begin
            errors++;
            aborted = 1'b1;
            $display("error at %0d ns: no packet arrived on fb within %0d cycles",
                     $time, WAIT_LIMIT);
        end
    endtask

    // Empty buffer, so the packet must show up one edge later
    task automatic bypass_push(input fetch_buffer_pkg::fetch_buffer_packet_t exp);
        assert (fb_valid === 1'b0)
        else begin
            errors++;
            $display("error at %0d ns: buffer not empty before a bypass push", $time);
        end
        fetch_in = exp.fetch;
        push     = 1'b1;
        tick();
        push = 1'b0;
        check_value("fb_valid", 32'(fb_valid), 32'd1);
        compare_packet(exp);
        if (fb_valid) begin
            pop = 1'b1;  // Consume it, buffer empty again
            tick();
            pop = 1'b0;
        end
    endtask

    task automatic burst_push(input fetch_buffer_pkg::fetch_buffer_packet_t exp);
        fetch_in = exp.fetch;
        push     = 1'b1;  // Pop stays low
        tick();
        push = 1'b0;
        expected_q.push_back(exp);
    endtask

    // Pop with random gaps, feeding pending packets in the pop cycles
    task automatic drain_burst();
        int gap;
        while (expected_q.size() > 0 && !aborted) begin
            gap = $urandom % 3;
            repeat (gap) tick();
            wait_valid();
            if (!aborted) begin
                compare_packet(expected_q.pop_front());
                pop = 1'b1;
                if (pending_q.size() > 0) begin
                    fetch_in = pending_q[0].fetch;
                    push     = 1'b1;  // Push and pop in one cycle
                    expected_q.push_back(pending_q.pop_front());
                end
                tick();
                pop  = 1'b0;
                push = 1'b0;
            end
        end
        check_value("fb_valid", 32'(fb_valid), 32'd0);  // Nothing duplicated
    endtask

    // Push in the flush cycle is dropped too
    task automatic flush_buffer(input fetch_buffer_pkg::fetch_buffer_packet_t dropped);
        fetch_in = dropped.fetch;
        push     = 1'b1;
        flush    = 1'b1;
        tick();
        push  = 1'b0;
        flush = 1'b0;
        check_value("fb_valid", 32'(fb_valid), 32'd0);
        expected_q.delete();
        pending_q.delete();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        int    fd;
        int    n;
        string line;
        byte   cmd;
        logic  in_burst;
        logic [31:0] instr_v, pc_v, meta_v, pred_v, way_v;
        logic [31:0] call_v, ret_v, rs1_v, rs2_v, rd_v;
        logic [31:0] req_v, sub_v, lop_v, s1_v, s2_v;
        fetch_buffer_pkg::fetch_buffer_packet_t exp;

        void'($urandom(49));
        errors       = 0;
        checks       = 0;
        aborted      = 1'b0;
        in_burst     = 1'b0;
        buffer_reset = 1'b1;
        flush        = 1'b0;
        push         = 1'b0;
        pop          = 1'b0;
        fetch_in     = '0;

        repeat (RESET_CYCLES) begin
            tick();
            check_value("fb_valid", 32'(fb_valid), 32'd0);  // Held empty in reset
        end
        buffer_reset = 1'b0;
        tick();
        check_value("fb_valid", 32'(fb_valid), 32'd0);

        fd = $fopen("dv/fetch_decode_patterns.txt", "r");
        assert (fd != 0)
        else begin
            errors++;
            aborted = 1'b1;
            $display("error: could not open the pattern file");
        end

        while (!aborted && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            cmd, instr_v, pc_v, meta_v, pred_v, way_v, call_v, ret_v,
                            rs1_v, rs2_v, rd_v, req_v, sub_v, lop_v, s1_v, s2_v);
                assert (n == 16)
                else begin
                    errors++;
                    $display("error: malformed pattern line: %s", line);
                end
                exp.fetch.instruction     = instr_v;
                exp.fetch.pc              = pc_v;
                exp.fetch.branch_metadata = meta_v;
                exp.fetch.prediction_used = pred_v[0];
                exp.fetch.update_way      = way_v[1:0];
                exp.is_call               = call_v[0];
                exp.is_return             = ret_v[0];
                exp.uses_rs1              = rs1_v[0];
                exp.uses_rs2              = rs2_v[0];
                exp.uses_rd               = rd_v[0];
                exp.alu_request           = req_v[0];
                exp.alu_sub               = sub_v[0];
                exp.alu_logic_op          = fetch_buffer_pkg::alu_logic_op_t'(lop_v[1:0]);
                exp.alu_rs1_sel           = fetch_buffer_pkg::alu_rs1_sel_t'(s1_v[1:0]);
                exp.alu_rs2_sel           = fetch_buffer_pkg::alu_rs2_sel_t'(s2_v[1:0]);
                case (cmd)
                    "P": begin
                        if (!in_burst)
                            bypass_push(exp);
                        else if (expected_q.size() < OUTSTANDING_MAX)
                            burst_push(exp);
                        else
                            pending_q.push_back(exp);  // Waits for a pop slot
                    end
                    "B": in_burst = 1'b1;
                    "E": begin
                        drain_burst();
                        in_burst = 1'b0;
                    end
                    "F": begin
                        flush_buffer(exp);
                        in_burst = 1'b0;
                    end
                    default: begin
                        errors++;
                        $display("error: unknown command in pattern line: %s", line);
                    end
                endcase
            end
        end
        if (fd != 0)
            $fclose(fd);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- dv/fetch_decode_patterns.txt
# cmd instr pc metadata pred_used update_way call ret rs1 rs2 rd req sub logic_op rs1_sel rs2_sel
# logic_op 0 add 1 xor 2 or 3 and, rs1_sel 0 rf 1 pc 2 zero, rs2_sel 0 rf 1 imm 2 jal 3 upper
P 100000EF 00001000 A5A50001 1 1 1 0 0 0 1 1 0 0 1 2  jal ra
P 00008067 00001004 A5A50002 1 2 0 1 1 0 1 1 0 0 1 2  jalr x0 ra, return
P 000080E7 00001008 A5A50003 0 1 1 0 1 0 1 1 0 0 1 2  jalr ra ra, call only
P 000280E7 0000100C A5A50004 0 2 1 1 1 0 1 1 0 0 1 2  jalr ra t0, call and return
P 000082E7 00001010 A5A50005 1 1 1 1 1 0 1 1 0 0 1 2  jalr t0 ra, call and return
P 0000006F 00001014 A5A50006 0 2 0 0 0 0 1 1 0 0 1 2  jal x0
P 300261F3 00001018 A5A50007 0 1 0 0 0 0 1 0 0 2 2 0  csrrsi
P 30039173 0000101C A5A50008 1 2 0 0 1 0 1 0 0 0 2 0  csrrw
P 00000073 00001020 A5A50009 0 1 0 0 0 0 0 0 0 0 2 0  ecall
P 402081B3 00001024 A5A5000A 1 1 0 0 1 1 1 1 1 0 0 0  sub
P 0062B233 00001028 A5A5000B 0 2 0 0 1 1 1 1 1 0 0 0  sltu
P 009443B3 0000102C A5A5000C 1 1 0 0 1 1 1 1 0 1 0 0  xor
P 12345537 00001030 A5A5000D 0 2 0 0 0 0 1 1 0 0 2 3  lui
P 00001597 00001034 A5A5000E 1 1 0 0 0 0 1 1 0 0 1 3  auipc
P 02E68633 00001038 A5A5000F 0 2 0 0 1 1 1 0 0 0 0 0  mul
P 00510093 0000103C A5A50010 1 1 0 0 1 0 1 1 0 0 0 1  addi
P 0FF37293 00001040 A5A50011 0 2 0 0 1 0 1 1 0 3 0 1  andi
P 0011E193 00001044 A5A50012 1 1 0 0 1 0 1 1 0 2 0 1  ori
P 00208463 00001048 A5A50013 0 2 0 0 1 1 0 0 0 0 2 0  beq
P 00410283 0000104C A5A50014 1 1 0 0 1 0 1 0 0 0 2 0  lb
P 00510423 00001050 A5A50015 0 2 0 0 1 1 0 0 0 0 2 0  sb
P 0FF0000F 00001054 A5A50016 1 1 0 0 0 0 0 0 0 0 2 0  fence
# Back-pressure burst, the last two go in with pops
B 00000000 00000000 00000000 0 0 0 0 0 0 0 0 0 0 0 0
P 402081B3 00002000 5A5A0001 0 1 0 0 1 1 1 1 1 0 0 0  sub
P 009443B3 00002004 5A5A0002 1 2 0 0 1 1 1 1 0 1 0 0  xor
P 12345537 00002008 5A5A0003 0 1 0 0 0 0 1 1 0 0 2 3  lui
P 00008067 0000200C 5A5A0004 1 2 0 1 1 0 1 1 0 0 1 2  ret
P 00510093 00002010 5A5A0005 0 1 0 0 1 0 1 1 0 0 0 1  addi
P 0062B233 00002014 5A5A0006 1 2 0 0 1 1 1 1 1 0 0 0  sltu
P 00001597 00002018 5A5A0007 0 1 0 0 0 0 1 1 0 0 1 3  auipc
E 00000000 00000000 00000000 0 0 0 0 0 0 0 0 0 0 0 0
# Flush with packets queued, then normal traffic
B 00000000 00000000 00000000 0 0 0 0 0 0 0 0 0 0 0 0
P 02E68633 00003000 3C3C0001 1 1 0 0 1 1 1 0 0 0 0 0  mul
P 0FF37293 00003004 3C3C0002 0 2 0 0 1 0 1 1 0 3 0 1  andi
P 100000EF 00003008 3C3C0003 1 1 1 0 0 0 1 1 0 0 1 2  jal ra
F 00208463 0000300C 3C3C0004 0 2 0 0 1 1 0 0 0 0 2 0  beq, dropped
P 0011E193 00004000 C3C30001 1 1 0 0 1 0 1 1 0 2 0 1  ori
P 000280E7 00004004 C3C30002 0 2 1 1 1 0 1 1 0 0 1 2  jalr ra t0
B 00000000 00000000 00000000 0 0 0 0 0 0 0 0 0 0 0 0
P 00410283 00005000 0F0F0001 1 1 0 0 1 0 1 0 0 0 2 0  lb
P 00510423 00005004 0F0F0002 0 2 0 0 1 1 0 0 0 0 2 0  sb
P 00000073 00005008 0F0F0003 1 1 0 0 0 0 0 0 0 0 2 0  ecall
E 00000000 00000000 00000000 0 0 0 0 0 0 0 0 0 0 0 0
P 0FF0000F 00006000 F0F00001 0 1 0 0 0 0 0 0 0 0 2 0  fence

//--- build.f
common/rv_isa_pkg.sv
common/fetch_buffer_pkg.sv
pre_decode/fetch_fifo.sv
pre_decode/pre_decode.sv
source/fetch_decode_top.sv
dv/tb_fetch_decode.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the fetch buffer testbench with Verilator and runs it.
# The run counts as passed only if the pass line shows up in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_fetch_decode \
    -f build.f \
    -o tb_fetch_decode \
    && ./obj_dir/tb_fetch_decode | tee /dev/stderr | grep -q "STATUS: PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
